/* rhd_cmd_pkg.sv */
package rhd_cmd_pkg;

    // Host op codes
    typedef logic [2:0] cmd_op_t;

    localparam cmd_op_t OP_CONVERT   = 3'd0;
    localparam cmd_op_t OP_CALIBRATE = 3'd1;
    localparam cmd_op_t OP_CLEAR     = 3'd2;
    localparam cmd_op_t OP_WRITE     = 3'd3;
    localparam cmd_op_t OP_READ      = 3'd4;

    // Register address or channel number, and register value
    typedef logic [5:0] reg_addr_t;
    typedef logic [7:0] reg_data_t;

    // Fixed command words
    localparam logic [15:0] CMD_CALIBRATE = 16'h5500;
    localparam logic [15:0] CMD_CLEAR     = 16'h6A00;

    // Prefix in bits 15:14, address in 13:8, data in 7:0
    localparam logic [1:0] PFX_CONVERT = 2'b00;
    localparam logic [1:0] PFX_WRITE   = 2'b10;
    localparam logic [1:0] PFX_READ    = 2'b11;

    // Upper result byte returned by the chip
    localparam reg_data_t RET_WRITE = 8'hFF;
    localparam reg_data_t RET_READ  = 8'h00;

    // Filler read when no host command waits
    localparam reg_addr_t FILLER_ADDR = 6'd63;

    // Frames between a command and its result
    localparam int RESULT_LAG = 2;

    typedef enum logic [2:0] {
        S_IDLE,
        S_PREP,
        S_START,
        S_WAIT_FRAME,
        S_WAIT_PERIOD
    } seq_state_t;

endpackage

/* rhd_spi_pkg.sv */
package rhd_spi_pkg;

    // One SPI frame
    localparam int FRAME_BITS = 16;
    typedef logic [FRAME_BITS-1:0] spi_word_t;

    // clk cycles per half sclk period
    localparam int SCLK_HALF = 2;

    // clk cycles with chip select high between frames
    localparam int CS_GAP = 4;

    // Counter widths in the master
    localparam int CNT_W = $clog2(CS_GAP + SCLK_HALF);
    localparam int BIT_W = $clog2(FRAME_BITS);

    typedef enum logic [1:0] {
        M_IDLE,
        M_SHIFT,
        M_GAP
    } spi_state_t;

endpackage

/* spi_frame_if.sv */
`timescale 1ns/100ps

interface spi_frame_if import rhd_spi_pkg::*; ();

    logic      start;
    spi_word_t tx_word;
    logic      frame_done;
    spi_word_t rx_word;
    logic      period_done;

    modport seq (
        output start, tx_word,
        input  frame_done, rx_word, period_done
    );

    modport master (
        input  start, tx_word,
        output frame_done, rx_word, period_done
    );

endinterface

/* rhd_spi_master.sv */
`timescale 1ns/100ps

module rhd_spi_master import rhd_spi_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    spi_frame_if.master frame,
    output logic        sclk,
    output logic        cs_n,
    output logic        mosi,
    input  logic        miso
);

    spi_state_t       state;
    logic [CNT_W-1:0] div_cnt;
    logic [BIT_W-1:0] bit_cnt;
    spi_word_t        tx_sr;
    spi_word_t        rx_sr;
    logic             half_end;
    logic             rise_pt;
    logic             fall_pt;
    logic             last_bit;

    // End of one half sclk period inside a frame
    assign half_end = (state == M_SHIFT) && (div_cnt == CNT_W'(SCLK_HALF - 1));
    assign rise_pt  = half_end && !sclk;
    assign fall_pt  = half_end && sclk;
    assign last_bit = (bit_cnt == BIT_W'(FRAME_BITS - 1));

    // MSB first
    assign mosi          = tx_sr[FRAME_BITS-1];
    assign frame.rx_word = rx_sr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state             <= M_IDLE;
            div_cnt           <= '0;
            bit_cnt           <= '0;
            sclk              <= 1'b0;
            cs_n              <= 1'b1;
            frame.frame_done  <= 1'b0;
            frame.period_done <= 1'b0;
        end else begin
            frame.frame_done  <= 1'b0;
            frame.period_done <= 1'b0;
            case (state)
                M_IDLE: begin
                    if (frame.start) begin
                        cs_n    <= 1'b0;
                        div_cnt <= '0;
                        bit_cnt <= '0;
                        state   <= M_SHIFT;
                    end
                end
                M_SHIFT: begin
                    if (half_end) begin
                        div_cnt <= '0;
                        if (!sclk) begin
                            sclk <= 1'b1;
                        end else begin
                            sclk <= 1'b0;
                            if (last_bit) begin
                                // Last fall closes the frame
                                cs_n             <= 1'b1;
                                frame.frame_done <= 1'b1;
                                state            <= M_GAP;
                            end else begin
                                bit_cnt <= bit_cnt + 1'b1;
                            end
                        end
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                M_GAP: begin
                    if (div_cnt == CNT_W'(CS_GAP - 1)) begin
                        div_cnt           <= '0;
                        frame.period_done <= 1'b1;
                        state             <= M_IDLE;
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= M_IDLE;
                end
            endcase
        end
    end

    // Shift registers load on start and move one bit per sclk period
    always_ff @(posedge clk) begin
        if (state == M_IDLE && frame.start) begin
            tx_sr <= frame.tx_word;
        end else if (fall_pt) begin
            tx_sr <= {tx_sr[FRAME_BITS-2:0], 1'b0};
        end
        // Sample miso at the rising edge of sclk
        if (rise_pt) begin
            rx_sr <= {rx_sr[FRAME_BITS-2:0], miso};
        end
    end

endmodule

/* rhd_cmd_seq.sv */
`timescale 1ns/100ps

module rhd_cmd_seq import rhd_cmd_pkg::*; import rhd_spi_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    spi_frame_if.seq   frame,
    input  logic       cmd_valid,
    input  cmd_op_t    cmd_op,
    input  reg_addr_t  cmd_addr,
    input  reg_data_t  cmd_data,
    output logic       cmd_lost,
    output logic       result_valid,
    output cmd_op_t    result_op,
    output spi_word_t  result_word
);

    seq_state_t state;

    // Pending command slot
    logic      pend_valid;
    cmd_op_t   pend_op;
    reg_addr_t pend_addr;
    reg_data_t pend_data;

    // Frame being sent and the frames still waiting for their result
    spi_word_t             tx_word;
    logic                  cur_host;
    cmd_op_t               cur_op;
    logic [RESULT_LAG-1:0] rec_host;
    cmd_op_t               rec_op [RESULT_LAG];

    function automatic spi_word_t encode_cmd(cmd_op_t op, reg_addr_t addr, reg_data_t data);
        case (op)
            OP_CONVERT:   return {PFX_CONVERT, addr, 8'h00};
            OP_CALIBRATE: return CMD_CALIBRATE;
            OP_CLEAR:     return CMD_CLEAR;
            OP_WRITE:     return {PFX_WRITE, addr, data};
            OP_READ:      return {PFX_READ, addr, 8'h00};
            default:      return {PFX_READ, FILLER_ADDR, 8'h00};
        endcase
    endfunction

    assign frame.start   = (state == S_START);
    assign frame.tx_word = tx_word;

    // Slot fills from the host and empties in S_PREP
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pend_valid <= 1'b0;
            cmd_lost   <= 1'b0;
        end else begin
            cmd_lost <= cmd_valid && pend_valid;
            if (cmd_valid && !pend_valid) begin
                pend_valid <= 1'b1;
            end else if (state == S_PREP) begin
                pend_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid && !pend_valid) begin
            pend_op   <= cmd_op;
            pend_addr <= cmd_addr;
            pend_data <= cmd_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= S_IDLE;
            cur_host     <= 1'b0;
            rec_host     <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    state <= S_PREP;
                end
                S_PREP: begin
                    cur_host <= pend_valid;
                    state    <= S_START;
                end
                S_START: begin
                    state <= S_WAIT_FRAME;
                end
                S_WAIT_FRAME: begin
                    if (frame.frame_done) begin
                        result_valid <= rec_host[RESULT_LAG-1];
                        rec_host     <= {rec_host[RESULT_LAG-2:0], cur_host};
                        state        <= S_WAIT_PERIOD;
                    end
                end
                S_WAIT_PERIOD: begin
                    if (frame.period_done) begin
                        state <= S_PREP;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // Command word, op record and result payload
    always_ff @(posedge clk) begin
        if (state == S_PREP) begin
            if (pend_valid) begin
                tx_word <= encode_cmd(pend_op, pend_addr, pend_data);
            end else begin
                tx_word <= {PFX_READ, FILLER_ADDR, 8'h00};
            end
            cur_op <= pend_op;
        end
        if (state == S_WAIT_FRAME && frame.frame_done) begin
            // Word arriving now belongs to the oldest frame in the record
            result_op   <= rec_op[RESULT_LAG-1];
            result_word <= frame.rx_word;
            for (int i = RESULT_LAG - 1; i > 0; i--) begin
                rec_op[i] <= rec_op[i-1];
            end
            rec_op[0] <= cur_op;
        end
    end

endmodule

/* rhd_ctrl_top.sv */
`timescale 1ns/100ps

module rhd_ctrl_top import rhd_cmd_pkg::*; import rhd_spi_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    // Host side
    input  logic      cmd_valid,
    input  cmd_op_t   cmd_op,
    input  reg_addr_t cmd_addr,
    input  reg_data_t cmd_data,
    output logic      cmd_lost,
    output logic      result_valid,
    output cmd_op_t   result_op,
    output spi_word_t result_word,
    // Chip side
    output logic      sclk,
    output logic      cs_n,
    output logic      mosi,
    input  logic      miso
);

    spi_frame_if frame ();

    rhd_cmd_seq u_seq (
        .clk          (clk),
        .rst          (rst),
        .frame        (frame.seq),
        .cmd_valid    (cmd_valid),
        .cmd_op       (cmd_op),
        .cmd_addr     (cmd_addr),
        .cmd_data     (cmd_data),
        .cmd_lost     (cmd_lost),
        .result_valid (result_valid),
        .result_op    (result_op),
        .result_word  (result_word)
    );

    rhd_spi_master u_spi (
        .clk   (clk),
        .rst   (rst),
        .frame (frame.master),
        .sclk  (sclk),
        .cs_n  (cs_n),
        .mosi  (mosi),
        .miso  (miso)
    );

endmodule

/* tb_clk_gen.sv */
`timescale 1ns/100ps

module tb_clk_gen #(
    parameter int PERIOD_NS = 4
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(PERIOD_NS / 2.0) clk = ~clk;

endmodule

/* rhd_chip_model.sv */
`timescale 1ns/100ps

module rhd_chip_model #(
    parameter logic [7:0] REG_INIT_XOR = 8'h5A
) (
    input  logic sclk,
    input  logic cs_n,
    input  logic mosi,
    output logic miso
);

    logic [7:0]  regs [64];
    logic [15:0] rx_sr = '0;
    logic [15:0] tx_sr = '0;
    logic [15:0] answer;
    int          nbits = 0;

    // Answers in flight with index 1 going out in the next frame
    logic [15:0] pipe [2];

    initial begin
        for (int i = 0; i < 64; i++) begin
            regs[i] = 8'(i) ^ REG_INIT_XOR;
        end
        pipe[0] = '0;
        pipe[1] = '0;
        miso = 1'b0;
    end

    always @(negedge cs_n) begin
        nbits = 0;
        tx_sr = pipe[1];
        miso = tx_sr[15];
    end

    always @(posedge sclk) begin
        if (!cs_n) begin
            rx_sr = {rx_sr[14:0], mosi};
            nbits++;
        end
    end

    always @(negedge sclk) begin
        if (!cs_n) begin
            tx_sr = {tx_sr[14:0], 1'b0};
            miso = tx_sr[15];
        end
    end

    // Decode a complete frame when chip select rises
    always @(posedge cs_n) begin
        if (nbits == 16) begin
            case (rx_sr[15:14])
                2'b00: answer = 16'h8000 ^ {10'd0, rx_sr[13:8]};
                2'b10: begin
                    answer = {8'hFF, rx_sr[7:0]};
                    if (rx_sr[13:8] < 6'd22) begin
                        regs[rx_sr[13:8]] = rx_sr[7:0];
                    end
                end
                2'b11: answer = {8'h00, regs[rx_sr[13:8]]};
                // Calibrate and clear
                default: answer = 16'h0000;
            endcase
            pipe[1] = pipe[0];
            pipe[0] = answer;
        end
    end

endmodule

/* rhd_ctrl_chk.sv */
`timescale 1ns/100ps

module rhd_ctrl_chk import rhd_spi_pkg::*; (
    input logic       clk,
    input logic       rst,
    input spi_state_t state,
    input logic       start,
    input logic       sclk,
    input logic       cs_n,
    input logic       mosi
);

    // Chip select stays high outside a frame
    cs_high_outside_frame: assert property (@(posedge clk) disable iff (rst)
        (state == M_IDLE || state == M_GAP) |-> cs_n)
        else $error("cs_n low while the master is idle or in the gap");

    sclk_low_when_deselected: assert property (@(posedge clk) disable iff (rst)
        cs_n |-> !sclk)
        else $error("sclk high while cs_n is high");

    start_only_when_idle: assert property (@(posedge clk) disable iff (rst)
        start |-> (state == M_IDLE))
        else $error("start seen while a frame or gap is running");

    // Chip samples mosi while sclk is high
    mosi_stable_sclk_high: assert property (@(posedge clk) disable iff (rst)
        sclk |-> $stable(mosi))
        else $error("mosi changed while sclk was high");

endmodule

bind rhd_spi_master rhd_ctrl_chk u_chk (
    .clk   (clk),
    .rst   (rst),
    .state (state),
    .start (frame.start),
    .sclk  (sclk),
    .cs_n  (cs_n),
    .mosi  (mosi)
);

/* tb_rhd_ctrl.sv */
`timescale 1ns/100ps

module tb_rhd_ctrl import rhd_cmd_pkg::*; import rhd_spi_pkg::*; ();

    localparam int          CLK_NS       = 4;
    localparam int          FRAME_CYCLES = 71;
    localparam int          NUM_TESTS    = 6;
    localparam int          TEST_FRAMES  = 8;
    localparam int          WATCHDOG_NS  = NUM_TESTS * TEST_FRAMES * FRAME_CYCLES * CLK_NS * 2;
    localparam logic [31:0] LFSR_SEED    = 32'h13ad;
    localparam logic [7:0]  REG_INIT_XOR = 8'h5A;

    logic      clk;
    logic      rst;
    logic      cmd_valid;
    cmd_op_t   cmd_op;
    reg_addr_t cmd_addr;
    reg_data_t cmd_data;
    logic      cmd_lost;
    logic      result_valid;
    cmd_op_t   result_op;
    spi_word_t result_word;
    logic      sclk;
    logic      cs_n;
    logic      mosi;
    logic      miso;

    logic [31:0] lfsr       = LFSR_SEED;
    int          mismatches = 0;
    int          failures   = 0;
    int          lost_count = 0;
    int          cs_rises   = 0;
    cmd_op_t     got_op[$];
    spi_word_t   got_word[$];
    cmd_op_t     exp_op[$];
    spi_word_t   exp_word[$];

    tb_clk_gen #(.PERIOD_NS(CLK_NS)) u_clk (.clk(clk));

    rhd_ctrl_top u_rhd_ctrl_top (
        .clk          (clk),
        .rst          (rst),
        .cmd_valid    (cmd_valid),
        .cmd_op       (cmd_op),
        .cmd_addr     (cmd_addr),
        .cmd_data     (cmd_data),
        .cmd_lost     (cmd_lost),
        .result_valid (result_valid),
        .result_op    (result_op),
        .result_word  (result_word),
        .sclk         (sclk),
        .cs_n         (cs_n),
        .mosi         (mosi),
        .miso         (miso)
    );

    rhd_chip_model #(.REG_INIT_XOR(REG_INIT_XOR)) u_chip (
        .sclk (sclk),
        .cs_n (cs_n),
        .mosi (mosi),
        .miso (miso)
    );

    // Collect results and lost strobes away from the active edge
    always @(negedge clk) begin
        if (result_valid) begin
            got_op.push_back(result_op);
            got_word.push_back(result_word);
        end
        if (cmd_lost) begin
            lost_count++;
        end
    end

    always @(posedge cs_n) begin
        cs_rises++;
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val = {val[30:0], lfsr[0]};
        end
    endtask

    task automatic compare(input string what, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0d ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // Returns at the first clock low phase after cs_n falls
    task automatic wait_frame_start();
        logic prev;
        prev = 1'b0;
        for (int n = 0; n < 2 * FRAME_CYCLES; n++) begin
            @(negedge clk);
            if (prev && !cs_n) begin
                return;
            end
            prev = cs_n;
        end
        failures++;
        $display("No frame started within %0d cycles, at %0d ns", 2 * FRAME_CYCLES, $time);
    endtask

    task automatic drive_cmd(input logic valid, input cmd_op_t op, input reg_addr_t addr,
                             input reg_data_t data);
        @(posedge clk);
        #1;
        cmd_valid = valid;
        cmd_op    = op;
        cmd_addr  = addr;
        cmd_data  = data;
    endtask

    // Slot is free right after a frame starts
    task automatic send_cmd(input cmd_op_t op, input reg_addr_t addr, input reg_data_t data,
                            input spi_word_t expect_word);
        wait_frame_start();
        drive_cmd(1'b1, op, addr, data);
        drive_cmd(1'b0, op, addr, data);
        exp_op.push_back(op);
        exp_word.push_back(expect_word);
    endtask

    task automatic check_results();
        for (int n = 0; n < (RESULT_LAG + 2) * FRAME_CYCLES; n++) begin
            if (got_op.size() >= exp_op.size()) begin
                break;
            end
            @(negedge clk);
        end
        if (got_op.size() < exp_op.size()) begin
            failures++;
            $display("Only %0d of %0d results arrived by %0d ns",
                     got_op.size(), exp_op.size(), $time);
        end
        while (exp_op.size() > 0 && got_op.size() > 0) begin
            compare("result op", 16'(got_op.pop_front()), 16'(exp_op.pop_front()));
            compare("result word", got_word.pop_front(), exp_word.pop_front());
        end
        exp_op.delete();
        exp_word.delete();
    endtask

    task automatic idle_frames();
        int  rises;
        time t_prev;
        compare("cs_n after reset", 16'(cs_n), 16'd1);
        compare("sclk after reset", 16'(sclk), 16'd0);
        compare("result_valid after reset", 16'(result_valid), 16'd0);
        compare("cmd_lost after reset", 16'(cmd_lost), 16'd0);
        wait_frame_start();
        t_prev = $time;
        for (int i = 0; i < 5; i++) begin
            rises = cs_rises;
            wait_frame_start();
            compare("frame period", 16'($time - t_prev), 16'(FRAME_CYCLES * CLK_NS));
            compare("cs_n rises per frame", 16'(cs_rises - rises), 16'd1);
            t_prev = $time;
        end
        compare("results while idle", 16'(got_op.size()), 16'd0);
    endtask

    task automatic write_then_read();
        logic [31:0] r;
        reg_addr_t   addr;
        reg_data_t   data;
        take_bits(5, r);
        addr = 6'(r % 22);
        take_bits(8, r);
        data = r[7:0];
        send_cmd(OP_WRITE, addr, data, {8'hFF, data});
        send_cmd(OP_READ, addr, 8'h00, {8'h00, data});
        check_results();
    endtask

    task automatic convert_channels();
        logic [31:0] r;
        reg_addr_t   ch;
        for (int i = 0; i < 4; i++) begin
            take_bits(6, r);
            ch = r[5:0];
            send_cmd(OP_CONVERT, ch, 8'h00, 16'h8000 ^ {10'd0, ch});
        end
        check_results();
    endtask

    task automatic calibrate_and_clear();
        send_cmd(OP_CALIBRATE, 6'd0, 8'h00, 16'h0000);
        send_cmd(OP_CLEAR, 6'd0, 8'h00, 16'h0000);
        check_results();
    endtask

    // Writes never reach addresses from 22 up
    task automatic read_untouched();
        logic [31:0] r;
        reg_addr_t   addr;
        take_bits(6, r);
        addr = 6'(22 + r % 42);
        send_cmd(OP_READ, addr, 8'h00, {8'h00, {2'b00, addr} ^ REG_INIT_XOR});
        check_results();
    endtask

    task automatic dropped_command();
        logic [31:0] r;
        reg_addr_t   ch;
        int          lost_before;
        take_bits(6, r);
        ch = r[5:0];
        lost_before = lost_count;
        wait_frame_start();
        drive_cmd(1'b1, OP_CONVERT, ch, 8'h00);
        // Second strobe finds the slot full
        drive_cmd(1'b1, OP_READ, 6'd5, 8'h00);
        drive_cmd(1'b0, OP_READ, 6'd5, 8'h00);
        exp_op.push_back(OP_CONVERT);
        exp_word.push_back(16'h8000 ^ {10'd0, ch});
        check_results();
        repeat (RESULT_LAG + 1) wait_frame_start();
        compare("cmd_lost pulses", 16'(lost_count - lost_before), 16'd1);
        compare("results after dropped command", 16'(got_op.size()), 16'd0);
    endtask

    initial begin
        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd_op    = OP_CONVERT;
        cmd_addr  = '0;
        cmd_data  = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        idle_frames();
        write_then_read();
        convert_channels();
        calibrate_and_clear();
        read_untouched();
        dropped_command();
        compare("leftover results", 16'(got_op.size()), 16'd0);
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        failures++;
        $display("Run did not finish within %0d ns", WATCHDOG_NS);
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        $display("test failed");
        $finish;
    end

endmodule

/* flist.f */
rhd_cmd_pkg.sv
rhd_spi_pkg.sv
spi_frame_if.sv
rhd_spi_master.sv
rhd_cmd_seq.sv
rhd_ctrl_top.sv
tb_clk_gen.sv
rhd_chip_model.sv
rhd_ctrl_chk.sv
tb_rhd_ctrl.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rhd_ctrl -f flist.f -o tb_rhd_ctrl_sim

./obj_dir/tb_rhd_ctrl_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -qx "test passed" sim.log; then
    exit 0
fi
exit 1
